// ==== vlog.f ====
+incdir+rtl
rtl/branch_pkg.sv
rtl/branch_cmp_alu.sv
rtl/branch_ctrl_unit.sv
rtl/branch_target_calc.sv
rtl/issue_credit_fifo.sv
rtl/branch_resolve_top.sv
verif/clk_gen.sv
verif/branch_resolve_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= branch_resolve_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/branch_resolve_tb.sv ====
/*
 * Branch resolve stage testbench
 * Table of instructions with expected PC source, credit-obeying
 * driver, in-order checker and credit accounting
 */
`include "branch_defines.svh"

module branch_resolve_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import branch_pkg::*;

    localparam int TIMEOUT = 500;

    logic       clk;
    logic       rst;
    logic       in_valid = 1'b0;
    issue_pkt_t in_pkt = '0;
    logic       res_credit = 1'b0;
    logic       in_credit;
    logic       res_valid;
    redirect_t  res;

    issue_pkt_t tbl_pkt[$];        // Stimulus column
    pc_src_e    tbl_src[$];        // Expected PC source column
    redirect_t  exp_q[$];          // Records still owed by the DUT

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int in_credits = `BR_FIFO_DEPTH;  // Producer side view
    int max_credits = `BR_FIFO_DEPTH; // Highest producer credit count seen
    int sent = 0;
    int credit_pulses = 0;
    int rcv_cnt = 0;
    int owed = 0;                  // Consumer credits not yet returned
    int ret_wait = 0;
    int ret_delay = 2;
    bit hold = 1'b0;               // Withhold consumer credits

    clk_gen u_clk (.o_clk(clk), .o_rst(rst));

    branch_resolve_top uut (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_in_valid   (in_valid),
        .i_in_pkt     (in_pkt),
        .i_res_credit (res_credit),
        .o_in_credit  (in_credit),
        .o_res_valid  (res_valid),
        .o_res        (res)
    );

    task automatic check(input logic [66:0] got, input logic [66:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // Expected PC source straight from the RISC-V branch rules
    function automatic pc_src_e model_src(input issue_pkt_t p);
        logic taken;
        taken = 1'b0;
        case (p.func3)
            F3_BEQ:  taken = (p.rs1 == p.rs2);
            F3_BNE:  taken = (p.rs1 != p.rs2);
            F3_BLT:  taken = ($signed(p.rs1) < $signed(p.rs2));
            F3_BGE:  taken = ($signed(p.rs1) >= $signed(p.rs2));
            F3_BLTU: taken = (p.rs1 < p.rs2);
            F3_BGEU: taken = (p.rs1 >= p.rs2);
            default: taken = 1'b0;
        endcase
        if (p.opcode == OP_JAL) return PC_IMM;
        if (p.opcode == OP_JALR) return RS1_IMM;
        if (p.opcode == OP_BRANCH && taken) return PC_IMM;
        return PC_PLUS4;
    endfunction

    // Full record for a given source
    function automatic redirect_t model_res(input issue_pkt_t p, input pc_src_e src);
        redirect_t r;
        logic [`BR_NB_DATA-1:0] sum;
        sum = p.rs1 + p.imm;
        r.pc_src = src;
        r.flush  = (src != PC_PLUS4);
        r.link   = p.pc + 32'd4;
        case (src)
            PC_IMM:  r.target = p.pc + p.imm;
            RS1_IMM: r.target = {sum[31:1], 1'b0};
            default: r.target = p.pc + 32'd4;
        endcase
        return r;
    endfunction

    task automatic add(input logic [31:0] pc, input logic [6:0] op, input logic [2:0] f3,
                       input logic [31:0] rs1, input logic [31:0] rs2,
                       input logic [31:0] imm, input pc_src_e src);
        issue_pkt_t p;
        p.pc = pc;
        p.opcode = opcode_e'(op);
        p.func3 = func3_e'(f3);
        p.rs1 = rs1;
        p.rs2 = rs2;
        p.imm = imm;
        tbl_pkt.push_back(p);
        tbl_src.push_back(src);
    endtask

    // Waits for a producer credit, then pushes one packet
    task automatic send(input issue_pkt_t p, input redirect_t exp);
        int t;
        t = 0;
        while (in_credits == 0) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                $display("Stall: no input credit came back from the stage");
                $display("TESTS FAILED");
                $finish;
            end
        end
        in_valid = 1'b1;
        in_pkt = p;
        in_credits--;
        exp_q.push_back(exp);
        sent++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drained(input string what);
        int t;
        t = 0;
        while (exp_q.size() != 0 || owed != 0) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                $display("Stall: stage did not drain during %s", what);
                $display("TESTS FAILED");
                $finish;
            end
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
    endtask

    // Consumer and credit monitor, sampled where outputs are stable
    always @(negedge clk) begin
        res_credit = 1'b0;
        if (!rst) begin
            if (in_credit) begin
                in_credits++;
                credit_pulses++;
                if (in_credits > max_credits) begin
                    max_credits = in_credits;
                end
            end
            if (res_valid) begin
                rcv_cnt++;
                owed++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Record arrived at %0t ns with nothing expected", $time);
                end else begin
                    check(res, exp_q.pop_front(), "redirect record");
                end
            end
            if (!hold && owed > 0) begin
                if (ret_wait >= ret_delay) begin
                    res_credit = 1'b1;
                    owed--;
                    ret_wait = 0;
                end else begin
                    ret_wait++;
                end
            end
        end
    end

    initial begin
        int e0;
        int t;
        int rcv0;
        issue_pkt_t p;
        func3_e f3_list[6];
        f3_list = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        void'($urandom(34891));

        // pc, opcode, func3, rs1, rs2, imm, expected source
        add(32'h100, 7'b1100011, 3'b000, 32'd5, 32'd5, 32'h10, PC_IMM);
        add(32'h104, 7'b1100011, 3'b000, 32'd5, 32'd6, 32'h10, PC_PLUS4);
        add(32'h108, 7'b1100011, 3'b001, 32'd5, 32'd6, 32'hFFFFFFF0, PC_IMM);
        add(32'h10C, 7'b1100011, 3'b001, 32'd7, 32'd7, 32'h20, PC_PLUS4);
        add(32'h110, 7'b1100011, 3'b100, 32'h80000000, 32'd1, 32'h40, PC_IMM);
        add(32'h114, 7'b1100011, 3'b110, 32'h80000000, 32'd1, 32'h40, PC_PLUS4);
        add(32'h118, 7'b1100011, 3'b101, 32'hFFFFFFFF, 32'd0, 32'h8, PC_PLUS4);
        add(32'h11C, 7'b1100011, 3'b111, 32'hFFFFFFFF, 32'd0, 32'h8, PC_IMM);
        add(32'h120, 7'b1100011, 3'b100, 32'hFFFFFFFF, 32'd0, 32'hC, PC_IMM);
        add(32'h124, 7'b1100011, 3'b110, 32'd0, 32'hFFFFFFFF, 32'hC, PC_IMM);
        add(32'h128, 7'b1100011, 3'b101, 32'd3, 32'd3, 32'h18, PC_IMM);
        add(32'h12C, 7'b1100011, 3'b111, 32'd3, 32'd3, 32'h18, PC_IMM);
        add(32'h130, 7'b1100011, 3'b010, 32'd1, 32'd2, 32'h18, PC_PLUS4);
        add(32'h134, 7'b1100011, 3'b011, 32'd9, 32'd9, 32'h18, PC_PLUS4);
        add(32'h138, 7'b1101111, 3'b000, 32'd0, 32'd0, 32'hFFFFFF00, PC_IMM);
        add(32'h13C, 7'b1100111, 3'b000, 32'h1001, 32'd0, 32'h4, RS1_IMM);
        add(32'h140, 7'b1100111, 3'b000, 32'h2000, 32'd0, 32'hFFFFFFFF, RS1_IMM);
        add(32'h144, 7'b0110011, 3'b000, 32'd4, 32'd4, 32'h10, PC_PLUS4);
        add(32'h148, 7'b0010011, 3'b001, 32'd1, 32'd2, 32'h10, PC_PLUS4);
        add(32'h14C, 7'b0000011, 3'b100, 32'hFFFFFFFF, 32'd0, 32'h10, PC_PLUS4);

        // Outputs quiet through reset and one cycle after
        e0 = errors;
        t = 0;
        @(posedge clk);
        while (rst) begin
            @(negedge clk);
            check(67'({res_valid, in_credit}), 67'd0, "outputs during reset");
            @(posedge clk);  // Reset is read away from its release edge
            t++;
            if (t > TIMEOUT) begin
                $display("Stall: reset was never released");
                $display("TESTS FAILED");
                $finish;
            end
        end
        @(negedge clk);
        check(67'({res_valid, in_credit}), 67'd0, "outputs after reset");
        report("reset quiet", e0);

        // Directed table, credits returned with a short delay
        e0 = errors;
        for (int i = 0; i < tbl_pkt.size(); i++) begin
            send(tbl_pkt[i], model_res(tbl_pkt[i], tbl_src[i]));
        end
        wait_drained("directed table");
        report("branch, jump and fall-through table", e0);

        // Random branches, expectations from the rules only
        e0 = errors;
        ret_delay = 0;
        for (int i = 0; i < 12; i++) begin
            p.pc = ($urandom() % 32'h10000) << 2;
            p.opcode = OP_BRANCH;
            p.func3 = f3_list[$urandom_range(0, 5)];
            p.rs1 = $urandom();
            p.rs2 = (i % 3 == 0) ? p.rs1 : $urandom();
            p.imm = ($urandom() % 32'h1000) << 1;
            send(p, model_res(p, model_src(p)));
        end
        wait_drained("random branches");
        report("random branches", e0);

        // Back-pressure: only the initial output credits get through
        e0 = errors;
        hold = 1'b1;
        rcv0 = rcv_cnt;
        for (int i = 0; i < 6; i++) begin
            send(tbl_pkt[i], model_res(tbl_pkt[i], tbl_src[i]));
        end
        t = 0;
        while (t < 30) begin
            @(negedge clk);
            t++;
        end
        check(67'(rcv_cnt - rcv0), 67'(`BR_RES_CREDITS), "records under back-pressure");
        hold = 1'b0;
        ret_delay = 3;
        wait_drained("back-pressure release");
        check(67'(rcv_cnt - rcv0), 67'd6, "records after release");
        report("back-pressure", e0);

        // Credit accounting over the whole run
        e0 = errors;
        check(67'(credit_pulses), 67'(sent), "input credit pulses");
        check(67'(in_credits), 67'(`BR_FIFO_DEPTH), "producer credits after drain");
        check(67'(max_credits <= `BR_FIFO_DEPTH), 67'd1, "producer credits within queue depth");
        report("credit accounting", e0);

        $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/clk_gen.sv ====
/*
 * Testbench clock and reset
 * 10 ns clock, active-high reset held for 8 cycles
 */
module clk_gen (
    output logic o_clk,
    output logic o_rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;  // 10 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (8) @(posedge o_clk);
        @(negedge o_clk);  // Release away from the active edge
        o_rst = 1'b0;
    end

endmodule

// ==== rtl/branch_resolve_top.sv ====
/*
 * Branch resolve stage
 * Queues issued instructions, resolves the head when an output
 * credit is held and registers the redirect record
 */
`include "branch_defines.svh"

module branch_resolve_top (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_in_valid,
    input  branch_pkg::issue_pkt_t i_in_pkt,
    input  logic                   i_res_credit,
    output logic                   o_in_credit,
    output logic                   o_res_valid,
    output branch_pkg::redirect_t  o_res
);

    import branch_pkg::*;

    localparam int CNT_W = $clog2(`BR_RES_CREDITS + 1);

    issue_pkt_t             head;
    logic                   fifo_empty;
    logic                   pop;
    logic [CNT_W-1:0]       res_cnt;    // Consumer credits on hand
    logic                   alu_zero;
    logic [`BR_NB_DATA-1:0] alu_result;
    pc_src_e                pc_src;
    logic                   flush;
    logic [`BR_NB_DATA-1:0] target;
    logic [`BR_NB_DATA-1:0] link;
    redirect_t              res_d;

    issue_credit_fifo #(
        .T     (issue_pkt_t),
        .DEPTH (`BR_FIFO_DEPTH)
    ) u_fifo (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_push   (i_in_valid),  // Producer only sends with credit
        .i_data   (i_in_pkt),
        .i_pop    (pop),
        .o_data   (head),
        .o_empty  (fifo_empty),
        .o_credit (o_in_credit)
    );

    // Resolve only with something queued and room downstream
    assign pop = !fifo_empty && (res_cnt != '0);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            res_cnt <= CNT_W'(`BR_RES_CREDITS);
        end else begin
            case ({pop, i_res_credit})
                2'b10:   res_cnt <= res_cnt - CNT_W'(1);
                2'b01:   res_cnt <= res_cnt + CNT_W'(1);
                default: res_cnt <= res_cnt;
            endcase
        end
    end

    branch_cmp_alu #(
        .NB_DATA (`BR_NB_DATA)
    ) u_alu (
        .i_rs1        (head.rs1),
        .i_rs2        (head.rs2),
        .i_func3      (head.func3),
        .o_alu_zero   (alu_zero),
        .o_alu_result (alu_result)
    );

    branch_ctrl_unit #(
        .NB_DATA (`BR_NB_DATA)
    ) u_ctrl (
        .i_opcode     (head.opcode),
        .i_func3      (head.func3),
        .i_alu_zero   (alu_zero),
        .i_alu_result (alu_result),
        .o_pc_src     (pc_src),
        .o_flush      (flush)
    );

    branch_target_calc #(
        .NB_DATA (`BR_NB_DATA)
    ) u_target (
        .i_pc     (head.pc),
        .i_rs1    (head.rs1),
        .i_imm    (head.imm),
        .i_pc_src (pc_src),
        .o_target (target),
        .o_link   (link)
    );

    always_comb begin
        res_d.pc_src = pc_src;
        res_d.flush  = flush;
        res_d.target = target;
        res_d.link   = link;
    end

    // Valid follows the pop by one cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= pop;
        end
    end

    always_ff @(posedge i_clk) begin
        if (pop) begin
            o_res <= res_d;  // Held until the next pop
        end
    end

endmodule

// ==== rtl/issue_credit_fifo.sv ====
/*
 * Credit-returning issue queue
 * Circular buffer for any payload type, one credit pulse
 * back to the producer per popped entry
 */
`include "branch_defines.svh"

module issue_credit_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `BR_FIFO_DEPTH
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_push,
    input  T     i_data,
    input  logic i_pop,
    output T     o_data,
    output logic o_empty,
    output logic o_credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Next slot with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PTR_W'(1);
        end
        return nxt;
    endfunction

    // Storage only
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (i_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;  // Both or neither
            endcase
            o_credit <= i_pop;  // Slot freed, hand it back
        end
    end

    assign o_data  = mem[rd_ptr];  // Head, read combinationally
    assign o_empty = (count == '0);

endmodule

// ==== rtl/branch_target_calc.sv ====
/*
 * Branch target calculator
 * Builds the next fetch address for the chosen PC source
 * and the PC+4 link value
 */
`include "branch_defines.svh"

module branch_target_calc #(
    parameter int NB_DATA = `BR_NB_DATA
) (
    input  logic [NB_DATA-1:0]  i_pc,
    input  logic [NB_DATA-1:0]  i_rs1,
    input  logic [NB_DATA-1:0]  i_imm,
    input  branch_pkg::pc_src_e i_pc_src,
    output logic [NB_DATA-1:0]  o_target,
    output logic [NB_DATA-1:0]  o_link
);

    import branch_pkg::*;

    logic [NB_DATA-1:0] pc_plus4;
    logic [NB_DATA-1:0] pc_imm;
    logic [NB_DATA-1:0] rs1_imm;

    assign pc_plus4 = i_pc + NB_DATA'(4);
    assign pc_imm   = i_pc + i_imm;
    assign rs1_imm  = i_rs1 + i_imm;

    assign o_link = pc_plus4;  // Return address for JAL/JALR

    always_comb begin
        case (i_pc_src)
            PC_IMM:  o_target = pc_imm;
            // JALR drops the low bit of the sum
            RS1_IMM: o_target = {rs1_imm[NB_DATA-1:1], 1'b0};
            default: o_target = pc_plus4;
        endcase
    end

endmodule

// ==== rtl/branch_ctrl_unit.sv ====
/*
 * Branch control unit
 * Picks the PC source and the pipeline flush from opcode,
 * func3 and the compare ALU flags
 */
`include "branch_defines.svh"

module branch_ctrl_unit #(
    parameter int NB_DATA = `BR_NB_DATA
) (
    input  branch_pkg::opcode_e i_opcode,
    input  branch_pkg::func3_e  i_func3,
    input  logic                i_alu_zero,
    input  logic [NB_DATA-1:0]  i_alu_result,
    output branch_pkg::pc_src_e o_pc_src,
    output logic                o_flush
);

    import branch_pkg::*;

    logic less_than;
    logic br_taken;

    assign less_than = i_alu_result[0];  // Compare lands in bit 0

    // Condition per branch kind
    always_comb begin
        br_taken = 1'b0;
        case (i_func3)
            F3_BEQ:  br_taken = i_alu_zero;
            F3_BNE:  br_taken = !i_alu_zero;
            F3_BLT:  br_taken = less_than;
            F3_BGE:  br_taken = !less_than;
            F3_BLTU: br_taken = less_than;   // ALU did the unsigned compare
            F3_BGEU: br_taken = !less_than;
            default: br_taken = 1'b0;        // Unused codes never taken
        endcase
    end

    always_comb begin
        o_pc_src = PC_PLUS4;  // Fall through unless redirected
        case (i_opcode)
            OP_BRANCH: begin
                if (br_taken) begin
                    o_pc_src = PC_IMM;
                end
            end
            OP_JAL:  o_pc_src = PC_IMM;
            OP_JALR: o_pc_src = RS1_IMM;
            default: o_pc_src = PC_PLUS4;
        endcase
    end

    // Any redirect kills the younger instructions
    assign o_flush = (o_pc_src != PC_PLUS4);

endmodule

// ==== rtl/branch_cmp_alu.sv ====
/*
 * Branch compare ALU
 * Subtracts the operands, flags equality and puts the
 * signed or unsigned less-than in result bit 0
 */
`include "branch_defines.svh"

module branch_cmp_alu #(
    parameter int NB_DATA = `BR_NB_DATA
) (
    input  logic [NB_DATA-1:0] i_rs1,
    input  logic [NB_DATA-1:0] i_rs2,
    input  branch_pkg::func3_e i_func3,
    output logic               o_alu_zero,
    output logic [NB_DATA-1:0] o_alu_result
);

    logic [NB_DATA-1:0] diff;
    logic               lt_signed;
    logic               lt_unsigned;
    logic               use_unsigned;
    logic               less_than;

    assign diff = i_rs1 - i_rs2;

    // Equal operands leave nothing after the subtract
    assign o_alu_zero = (diff == '0);

    assign lt_signed   = $signed(i_rs1) < $signed(i_rs2);
    assign lt_unsigned = i_rs1 < i_rs2;

    // func3 bit 1 marks BLTU/BGEU
    assign use_unsigned = i_func3[1];
    assign less_than    = use_unsigned ? lt_unsigned : lt_signed;

    // Upper bits carry the difference, bit 0 the compare
    assign o_alu_result = {diff[NB_DATA-1:1], less_than};

endmodule

// ==== rtl/branch_pkg.sv ====
/*
 * Branch resolve types
 * Opcode, func3 and PC source encodings plus the issue and redirect records
 */
`include "branch_defines.svh"

package branch_pkg;

    // Control-flow opcodes, anything else falls through
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Conditional branch kinds, 010 and 011 left unused
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } func3_e;

    typedef enum logic [1:0] {
        PC_PLUS4 = 2'b00,   // Sequential fetch
        PC_IMM   = 2'b01,   // Taken branch or JAL
        RS1_IMM  = 2'b10    // JALR
    } pc_src_e;

    // Decoded instruction entering the stage
    typedef struct packed {
        logic [`BR_NB_DATA-1:0] pc;
        opcode_e                opcode;
        func3_e                 func3;
        logic [`BR_NB_DATA-1:0] rs1;
        logic [`BR_NB_DATA-1:0] rs2;
        logic [`BR_NB_DATA-1:0] imm;    // Already sign-extended
    } issue_pkt_t;

    // Resolution record sent to fetch
    typedef struct packed {
        pc_src_e                pc_src;
        logic                   flush;
        logic [`BR_NB_DATA-1:0] target;  // Next fetch address
        logic [`BR_NB_DATA-1:0] link;    // PC+4 for rd
    } redirect_t;

endpackage

// ==== rtl/branch_defines.svh ====
/*
 * Branch resolve stage sizing
 * Data width, issue queue depth and consumer credit count
 */
`ifndef BRANCH_DEFINES_SVH
`define BRANCH_DEFINES_SVH

// PC and operand width
`define BR_NB_DATA 32

// Issue queue entries, also the producer's starting credits
`define BR_FIFO_DEPTH 4

// Records the stage may send before the consumer returns any credit
`define BR_RES_CREDITS 2

`endif
